//--- hdl/nic_reg_pkg.sv
package nic_reg_pkg;

	// Host register byte offsets
	localparam logic [31:0] REG_CTRL = 32'h0000_0000;
	localparam logic [31:0] REG_MDIC = 32'h0000_0020;
	localparam logic [31:0] REG_ICR = 32'h0000_00C0;
	localparam logic [31:0] REG_ICS = 32'h0000_00C8;
	localparam logic [31:0] REG_IMS = 32'h0000_00D0;
	localparam logic [31:0] REG_IMC = 32'h0000_00D8;

	// MDIC field layout
	localparam int MDIC_DATA_LSB = 0;
	localparam int MDIC_DATA_W = 16;
	localparam int MDIC_REG_LSB = 16;
	localparam int MDIC_REG_W = 5;
	localparam int MDIC_OP_LSB = 26;
	localparam int MDIC_OP_W = 2;
	localparam int MDIC_READY_BIT = 28;
	localparam int MDIC_ERR_BIT = 30;

	// Clause-22 opcodes
	localparam logic [1:0] MDIO_OP_WRITE = 2'b01;
	localparam logic [1:0] MDIO_OP_READ = 2'b10;

	// Only one PHY sits on the management bus
	localparam logic [4:0] PHY_ADDR = 5'b00001;
	// aclk cycles per MDC half period
	localparam int MDC_DIV = 2;
	localparam int CTRL_PHY_RST_BIT = 31;
	localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

endpackage

//--- hdl/nic_intr_pkg.sv
package nic_intr_pkg;

	// Width of ICR, ICS, IMS and IMC
	localparam int INTR_W = 32;

	// Cause bit positions in ICR
	// MDIO access complete
	localparam int INTR_MDAC = 9;
	// PHY interrupt pin
	localparam int INTR_PHYINT = 12;

endpackage

//--- hdl/mdio_req_if.sv
`timescale 1ns/1ps

interface mdio_req_if
	import nic_reg_pkg::*;
();
	// Request side, taken from the MDIC image
	logic start;
	logic [MDIC_OP_W-1:0] op;
	logic [MDIC_REG_W-1:0] reg_addr;
	logic [MDIC_DATA_W-1:0] wdata;

	// Completion side
	logic [MDIC_DATA_W-1:0] rdata;
	logic busy;
	logic done;

	modport master (
		output start, op, reg_addr, wdata,
		input rdata, busy, done
	);

	modport slave (
		input start, op, reg_addr, wdata,
		output rdata, busy, done
	);

endinterface

//--- hdl/intr_reg_if.sv
`timescale 1ns/1ps

interface intr_reg_if
	import nic_intr_pkg::*;
();
	// Byte-masked host write data
	logic [INTR_W-1:0] wdata;
	// One-cycle strobes from the register decode
	logic ics_wr;
	logic ims_wr;
	logic imc_wr;
	logic icr_rd;

	// Current cause and mask images
	logic [INTR_W-1:0] icr;
	logic [INTR_W-1:0] ims;

	modport master (
		output wdata, ics_wr, ims_wr, imc_wr, icr_rd,
		input icr, ims
	);

	modport slave (
		input wdata, ics_wr, ims_wr, imc_wr, icr_rd,
		output icr, ims
	);

endinterface

//--- hdl/nic_regs.sv
`timescale 1ns/1ps

module nic_regs
	import nic_reg_pkg::*;
	import nic_intr_pkg::*;
(
	input logic aclk,
	input logic rst_i,
	// AXI4-Lite slave
	input logic [31:0] awaddr_i,
	input logic awvalid_i,
	output logic awready_o,
	input logic [31:0] wdata_i,
	input logic [3:0] wstrb_i,
	input logic wvalid_i,
	output logic wready_o,
	output logic [1:0] bresp_o,
	output logic bvalid_o,
	input logic bready_i,
	input logic [31:0] araddr_i,
	input logic arvalid_i,
	output logic arready_o,
	output logic [31:0] rdata_o,
	output logic [1:0] rresp_o,
	output logic rvalid_o,
	input logic rready_i,
	output logic [31:0] ctrl_o,
	mdio_req_if.master mdio,
	intr_reg_if.master intr
);
	logic wr_acc;
	logic rd_acc;
	logic wr_mdic;
	logic mdic_idle;
	logic start_q;
	logic [31:0] ctrl_q;
	logic [31:0] mdic_q;
	logic [31:0] mdic_wr;
	logic [31:0] intr_wdata;
	logic [31:0] rd_mux;

	// Byte-lane merge of host data over an old value
	function automatic logic [31:0] apply_strb(input logic [31:0] old_val,
		input logic [31:0] new_val, input logic [3:0] strb);
		logic [31:0] res;
		res = old_val;
		for (int i = 0; i < 4; i++)
		begin
			if (strb[i])
				res[8*i +: 8] = new_val[8*i +: 8];
		end
		return res;
	endfunction

	// Address and data accepted together, one write in flight
	assign wr_acc = awvalid_i && wvalid_i && !bvalid_o;
	assign awready_o = wr_acc;
	assign wready_o = wr_acc;
	assign bresp_o = AXI_RESP_OKAY;

	// Single outstanding read
	assign rd_acc = arvalid_i && !rvalid_o;
	assign arready_o = rd_acc;
	assign rresp_o = AXI_RESP_OKAY;

	// New MDIO command only with ready set and the master idle
	assign mdic_idle = mdic_q[MDIC_READY_BIT] && !mdio.busy;
	assign wr_mdic = wr_acc && (awaddr_i == REG_MDIC);
	assign mdic_wr = apply_strb(mdic_q, wdata_i, wstrb_i);

	always_ff @(posedge aclk)
	begin
		if (rst_i)
		begin
			bvalid_o <= 1'b0;
			ctrl_q <= '0;
			mdic_q <= '0;
			mdic_q[MDIC_READY_BIT] <= 1'b1;
			start_q <= 1'b0;
		end
		else
		begin
			start_q <= 1'b0;
			if (wr_acc)
				bvalid_o <= 1'b1;
			else if (bready_i)
				bvalid_o <= 1'b0;
			if (wr_acc && (awaddr_i == REG_CTRL))
				ctrl_q <= apply_strb(ctrl_q, wdata_i, wstrb_i);
			// Completion wins over a colliding host write
			if (mdio.done)
			begin
				mdic_q[MDIC_READY_BIT] <= 1'b1;
				if (mdic_q[MDIC_OP_LSB +: MDIC_OP_W] == MDIO_OP_READ)
					mdic_q[MDIC_DATA_LSB +: MDIC_DATA_W] <= mdio.rdata;
			end
			else if (wr_mdic && mdic_idle)
			begin
				mdic_q <= mdic_wr;
				mdic_q[MDIC_READY_BIT] <= 1'b0;
				mdic_q[MDIC_ERR_BIT] <= 1'b0;
				start_q <= 1'b1;
			end
			else if (wr_mdic)
				mdic_q[MDIC_ERR_BIT] <= 1'b1;  // dropped while busy
		end
	end

	assign ctrl_o = ctrl_q;

	// Request fields straight from the MDIC image
	assign mdio.start = start_q;
	assign mdio.op = mdic_q[MDIC_OP_LSB +: MDIC_OP_W];
	assign mdio.reg_addr = mdic_q[MDIC_REG_LSB +: MDIC_REG_W];
	assign mdio.wdata = mdic_q[MDIC_DATA_LSB +: MDIC_DATA_W];

	// Interrupt register strobes
	assign intr_wdata = apply_strb('0, wdata_i, wstrb_i);
	assign intr.wdata = intr_wdata[INTR_W-1:0];
	assign intr.ics_wr = wr_acc && (awaddr_i == REG_ICS);
	assign intr.ims_wr = wr_acc && (awaddr_i == REG_IMS);
	assign intr.imc_wr = wr_acc && (awaddr_i == REG_IMC);
	// ICR is captured below in the same cycle it clears
	assign intr.icr_rd = rd_acc && (araddr_i == REG_ICR);

	// Read decode, write-only and unmapped read as zero
	always_comb
	begin
		case (araddr_i)
			REG_CTRL: rd_mux = ctrl_q;
			REG_MDIC: rd_mux = mdic_q;
			REG_ICR: rd_mux = 32'(intr.icr);
			REG_IMS: rd_mux = 32'(intr.ims);
			default: rd_mux = '0;
		endcase
	end

	always_ff @(posedge aclk)
	begin
		if (rst_i)
			rvalid_o <= 1'b0;
		else if (rd_acc)
			rvalid_o <= 1'b1;
		else if (rready_i)
			rvalid_o <= 1'b0;
	end

	always_ff @(posedge aclk)
	begin
		if (rd_acc)
			rdata_o <= rd_mux;
	end

endmodule

//--- hdl/intr_ctrl.sv
`timescale 1ns/1ps

module intr_ctrl
	import nic_intr_pkg::*;
(
	input logic aclk,
	input logic rst_i,
	intr_reg_if.slave regs,
	input logic mdac_i,
	input logic phyint_i,
	output logic intr_o
);
	logic [INTR_W-1:0] hw_set;
	logic [INTR_W-1:0] cause_set;
	logic [INTR_W-1:0] icr_q;
	logic [INTR_W-1:0] ims_q;

	// Hardware cause pulses mapped to ICR bits
	always_comb
	begin
		hw_set = '0;
		hw_set[INTR_MDAC] = mdac_i;
		hw_set[INTR_PHYINT] = phyint_i;
	end

	// Software set through ICS
	assign cause_set = hw_set | (regs.ics_wr ? regs.wdata : '0);

	always_ff @(posedge aclk)
	begin
		if (rst_i)
		begin
			icr_q <= '0;
			ims_q <= '0;
			intr_o <= 1'b0;
		end
		else
		begin
			// Clear on read, new causes in the same cycle survive
			if (regs.icr_rd)
				icr_q <= cause_set;
			else
				icr_q <= icr_q | cause_set;
			// Mask set and clear by separate registers
			if (regs.ims_wr)
				ims_q <= ims_q | regs.wdata;
			else if (regs.imc_wr)
				ims_q <= ims_q & ~regs.wdata;
			// One cycle behind the cause image
			intr_o <= |(icr_q & ims_q);
		end
	end

	assign regs.icr = icr_q;
	assign regs.ims = ims_q;

endmodule

//--- hdl/mdio_master.sv
`timescale 1ns/1ps

module mdio_master
	import nic_reg_pkg::*;
(
	input logic aclk,
	input logic rst_i,
	mdio_req_if.slave req,
	output logic mdc_o,
	output logic mdio_o,
	output logic mdio_oe_o,
	input logic mdio_i
);
	logic [$clog2(MDC_DIV + 1)-1:0] div_cnt;
	logic [5:0] bit_cnt;
	logic [5:0] next_bit;
	logic [63:0] shift_q;
	logic [MDIC_DATA_W-1:0] rdata_q;
	logic rd_frame;
	logic busy_q;
	logic done_q;
	logic tick;

	// Half-period tick, MDC only runs during a frame
	assign tick = busy_q && (div_cnt == MDC_DIV - 1);
	assign next_bit = bit_cnt + 6'd1;

	always_ff @(posedge aclk)
	begin
		if (rst_i)
		begin
			busy_q <= 1'b0;
			done_q <= 1'b0;
			mdc_o <= 1'b0;
			mdio_oe_o <= 1'b0;
			div_cnt <= '0;
			bit_cnt <= '0;
			rd_frame <= 1'b0;
			// Idle line level is high
			shift_q <= '1;
		end
		else
		begin
			done_q <= 1'b0;
			if (req.start && !busy_q)
			begin
				busy_q <= 1'b1;
				div_cnt <= '0;
				bit_cnt <= '0;
				mdc_o <= 1'b0;
				mdio_oe_o <= 1'b1;
				rd_frame <= (req.op == MDIO_OP_READ);
				// Preamble, ST, OP, PHYAD, REGAD, TA, DATA
				shift_q <= {32'hFFFF_FFFF, 2'b01, req.op, PHY_ADDR, req.reg_addr,
					2'b10, req.wdata};
			end
			else if (busy_q)
			begin
				div_cnt <= tick ? '0 : div_cnt + 1'b1;
				if (tick && !mdc_o)
					mdc_o <= 1'b1;
				else if (tick)
				begin
					// Falling edge moves to the next bit
					mdc_o <= 1'b0;
					if (bit_cnt == 6'd63)
					begin
						busy_q <= 1'b0;
						done_q <= 1'b1;
						mdio_oe_o <= 1'b0;
						shift_q <= '1;
					end
					else
					begin
						bit_cnt <= next_bit;
						shift_q <= {shift_q[62:0], 1'b1};
						// Release from turnaround (bit 46) in reads
						if (rd_frame && next_bit >= 6'd46)
							mdio_oe_o <= 1'b0;
					end
				end
			end
		end
	end

	// Data bits 48 to 63 sampled on MDC rising edges
	always_ff @(posedge aclk)
	begin
		if (tick && !mdc_o && rd_frame && bit_cnt >= 6'd48)
			rdata_q <= {rdata_q[MDIC_DATA_W-2:0], mdio_i};
	end

	assign mdio_o = shift_q[63];
	assign req.rdata = rdata_q;
	assign req.busy = busy_q;
	assign req.done = done_q;

endmodule

//--- hdl/nic_ctrl_top.sv
`timescale 1ns/1ps

module nic_ctrl_top
	import nic_reg_pkg::*;
(
	input logic aclk,
	input logic rst_i,
	// Host register port
	input logic [31:0] awaddr_i,
	input logic awvalid_i,
	output logic awready_o,
	input logic [31:0] wdata_i,
	input logic [3:0] wstrb_i,
	input logic wvalid_i,
	output logic wready_o,
	output logic [1:0] bresp_o,
	output logic bvalid_o,
	input logic bready_i,
	input logic [31:0] araddr_i,
	input logic arvalid_i,
	output logic arready_o,
	output logic [31:0] rdata_o,
	output logic [1:0] rresp_o,
	output logic rvalid_o,
	input logic rready_i,
	output logic intr_o,
	// Management bus
	output logic mdc_o,
	input logic mdio_i,
	output logic mdio_o,
	output logic mdio_oe_o,
	// PHY misc
	input logic phy_int_i,
	output logic phy_reset_o
);
	logic [31:0] ctrl;
	logic [1:0] phy_int_sync;
	logic phy_int_d;
	logic phyint_pulse;

	mdio_req_if mdio_req_inst ();
	intr_reg_if intr_reg_inst ();

	// Two-flop synchronizer and rising-edge detect on the PHY pin
	always_ff @(posedge aclk)
	begin
		if (rst_i)
		begin
			phy_int_sync <= '0;
			phy_int_d <= 1'b0;
		end
		else
		begin
			phy_int_sync <= {phy_int_sync[0], phy_int_i};
			phy_int_d <= phy_int_sync[1];
		end
	end

	assign phyint_pulse = phy_int_sync[1] && !phy_int_d;
	// PHY held in reset by software or by system reset
	assign phy_reset_o = ctrl[CTRL_PHY_RST_BIT] || rst_i;

	nic_regs nic_regs_inst (
		.*,
		.ctrl_o(ctrl),
		.mdio(mdio_req_inst.master),
		.intr(intr_reg_inst.master)
	);

	// MDAC raised by the completion pulse
	intr_ctrl intr_ctrl_inst (
		.aclk(aclk),
		.rst_i(rst_i),
		.regs(intr_reg_inst.slave),
		.mdac_i(mdio_req_inst.done),
		.phyint_i(phyint_pulse),
		.intr_o(intr_o)
	);

	mdio_master mdio_master_inst (
		.*,
		.req(mdio_req_inst.slave)
	);

endmodule

//--- testbench/nic_ctrl_properties.sv
`timescale 1ns/1ps

module nic_ctrl_properties (
	input logic aclk,
	input logic rst_i,
	input logic awready_o,
	input logic bvalid_o,
	input logic bready_i,
	input logic rvalid_o,
	input logic rready_i,
	input logic mdio_oe_o,
	input logic mdio_busy
);
	// Write response held under back-pressure
	bvalid_hold: assert property (@(posedge aclk) disable iff (rst_i)
		bvalid_o && !bready_i |=> bvalid_o)
		else $error("bvalid dropped before bready");

	// Read data held under back-pressure
	rvalid_hold: assert property (@(posedge aclk) disable iff (rst_i)
		rvalid_o && !rready_i |=> rvalid_o)
		else $error("rvalid dropped before rready");

	// Line only driven inside a frame
	oe_idle: assert property (@(posedge aclk) disable iff (rst_i)
		!mdio_busy |-> !mdio_oe_o)
		else $error("mdio_oe_o high while the MDIO master is idle");

	// Accepted write answered on the next cycle
	aw_resp: assert property (@(posedge aclk) disable iff (rst_i)
		awready_o |=> bvalid_o)
		else $error("no write response after an accepted write");
endmodule

bind nic_ctrl_top nic_ctrl_properties nic_ctrl_properties_inst (
	.aclk(aclk),
	.rst_i(rst_i),
	.awready_o(awready_o),
	.bvalid_o(bvalid_o),
	.bready_i(bready_i),
	.rvalid_o(rvalid_o),
	.rready_i(rready_i),
	.mdio_oe_o(mdio_oe_o),
	.mdio_busy(mdio_req_inst.busy)
);

//--- testbench/tb_nic_ctrl.sv
`timescale 1ns/1ps

module tb_nic_ctrl
	import nic_reg_pkg::*;
	import nic_intr_pkg::*;
();
	typedef enum {K_WR, K_RD, K_MDIO_WR, K_MDIO_RD, K_PHYINT, K_INTR, K_PRST} kind_t;
	typedef struct {
		string name;
		kind_t kind;
		logic [31:0] addr;
		logic [31:0] wdata;
		logic [63:0] exp;
	} row_t;

	logic aclk = 1'b0;
	logic rst_i;
	logic [31:0] awaddr_i;
	logic awvalid_i;
	logic awready_o;
	logic [31:0] wdata_i;
	logic [3:0] wstrb_i;
	logic wvalid_i;
	logic wready_o;
	logic [1:0] bresp_o;
	logic bvalid_o;
	logic bready_i;
	logic [31:0] araddr_i;
	logic arvalid_i;
	logic arready_o;
	logic [31:0] rdata_o;
	logic [1:0] rresp_o;
	logic rvalid_o;
	logic rready_i;
	logic intr_o;
	logic mdc_o;
	logic mdio_i;
	logic mdio_o;
	logic mdio_oe_o;
	logic phy_int_i;
	logic phy_reset_o;

	row_t rows[$];
	string row_name = "";
	int errors = 0;
	int cycles = 0;
	int cycle_limit = 600;
	// PHY model state
	logic [15:0] phy_regs [32];
	logic [63:0] frame_sr = '1;
	logic [63:0] last_frame = '0;
	logic [1:0] phy_op = 2'b00;
	logic [4:0] phy_reg = 5'd0;
	int phy_bits = 0;

	nic_ctrl_top nic_ctrl_top_inst (.*);

	// 4 ns clock
	always #2 aclk = ~aclk;

	// Run limit scales with the table length
	always @(posedge aclk)
	begin
		cycles++;
		if (cycles >= cycle_limit)
		begin
			$display("Timeout, no completion after %0d cycles", cycles);
			$display("Simulation failed");
			$finish;
		end
	end

	// PHY samples on MDC rising edges
	always @(posedge mdc_o)
	begin
		// Master lets go of the line from the turnaround of a read
		if (mdio_oe_o !== !(phy_op == MDIO_OP_READ && phy_bits >= 46))
		begin
			errors++;
			$display("mdio_oe_o is %b at MDIO frame bit %0d", mdio_oe_o, phy_bits);
		end
		frame_sr = {frame_sr[62:0], mdio_o};
		phy_bits++;
		// Opcode and register number complete after 46 bits
		if (phy_bits == 46)
		begin
			phy_op = frame_sr[11:10];
			phy_reg = frame_sr[4:0];
		end
		if (phy_bits == 64)
		begin
			last_frame = frame_sr;
			phy_bits = 0;
		end
	end

	// Read data launched on MDC falling edges, MSB first
	always @(negedge mdc_o)
	begin
		if (phy_op == MDIO_OP_READ && phy_bits >= 48 && phy_bits <= 63)
			mdio_i <= phy_regs[phy_reg][63 - phy_bits];
		else
			mdio_i <= 1'b1;
	end

	// MDIC command word from its fields
	function automatic logic [31:0] mdic_cmd(input logic [1:0] op, input logic [4:0] ra,
		input logic [15:0] d);
		return (32'(op) << MDIC_OP_LSB) | (32'(ra) << MDIC_REG_LSB) | 32'(d);
	endfunction

	// Clause-22 frame as the PHY sees it
	function automatic logic [63:0] mdio_frame(input logic [1:0] op, input logic [4:0] ra,
		input logic [15:0] d);
		return {32'hFFFF_FFFF, 2'b01, op, PHY_ADDR, ra, 2'b10, d};
	endfunction

	task automatic add_row(input string n, input kind_t k, input logic [31:0] a,
		input logic [31:0] w, input logic [63:0] e);
		row_t r;
		r.name = n;
		r.kind = k;
		r.addr = a;
		r.wdata = w;
		r.exp = e;
		rows.push_back(r);
	endtask

	task automatic axi_write(input logic [31:0] addr, input logic [31:0] data);
		int stall;
		stall = $urandom % 4;
		@(posedge aclk);
		awaddr_i <= addr;
		wdata_i <= data;
		awvalid_i <= 1'b1;
		wvalid_i <= 1'b1;
		@(posedge aclk);
		while (!(awready_o && wready_o))
			@(posedge aclk);
		awvalid_i <= 1'b0;
		wvalid_i <= 1'b0;
		// Random response back-pressure
		repeat (stall) @(posedge aclk);
		bready_i <= 1'b1;
		@(posedge aclk);
		while (!bvalid_o)
			@(posedge aclk);
		// AXI OKAY response
		if (bresp_o !== 2'b00)
		begin
			errors++;
			$display("ERR %s bresp expected %h actual %h", row_name, 2'b00, bresp_o);
		end
		bready_i <= 1'b0;
	endtask

	task automatic axi_read(input logic [31:0] addr, output logic [31:0] data);
		int stall;
		stall = $urandom % 4;
		@(posedge aclk);
		araddr_i <= addr;
		arvalid_i <= 1'b1;
		@(posedge aclk);
		while (!arready_o)
			@(posedge aclk);
		arvalid_i <= 1'b0;
		repeat (stall) @(posedge aclk);
		rready_i <= 1'b1;
		@(posedge aclk);
		while (!rvalid_o)
			@(posedge aclk);
		data = rdata_o;
		if (rresp_o !== 2'b00)
		begin
			errors++;
			$display("ERR %s rresp expected %h actual %h", row_name, 2'b00, rresp_o);
		end
		rready_i <= 1'b0;
	endtask

	// Poll MDIC until the ready bit comes back
	task automatic wait_mdic_ready(output logic [31:0] mdic);
		mdic = '0;
		while (!mdic[MDIC_READY_BIT])
			axi_read(REG_MDIC, mdic);
	endtask

	task automatic build_table();
		logic [31:0] rdy;
		rdy = 32'h1 << MDIC_READY_BIT;
		// PHY register contents, every address distinct
		for (int i = 0; i < 32; i++)
			phy_regs[i] = 16'(i * 16'h0123) ^ 16'h5A5A;
		add_row("ctrl_rst", K_RD, REG_CTRL, 0, 0);
		add_row("icr_rst", K_RD, REG_ICR, 0, 0);
		add_row("ims_rst", K_RD, REG_IMS, 0, 0);
		add_row("mdic_rst", K_RD, REG_MDIC, 0, 64'(rdy));
		add_row("unmapped", K_RD, 32'h44, 0, 0);
		add_row("ctrl_wr", K_WR, REG_CTRL, 32'h8000_00A5, 0);
		add_row("ctrl_rd", K_RD, REG_CTRL, 0, 64'h8000_00A5);
		add_row("phy_rst_on", K_PRST, 0, 0, 1);
		add_row("ctrl_clr", K_WR, REG_CTRL, 32'h0000_00A5, 0);
		add_row("phy_rst_off", K_PRST, 0, 0, 0);
		// MDIO write, then MDAC stays masked
		add_row("mdio_wr", K_MDIO_WR, 0, mdic_cmd(MDIO_OP_WRITE, 5'd5, 16'hBEEF),
			mdio_frame(2'b01, 5'd5, 16'hBEEF));
		add_row("mdic_wr_done", K_RD, REG_MDIC, 0,
			64'(rdy | mdic_cmd(MDIO_OP_WRITE, 5'd5, 16'hBEEF)));
		add_row("intr_masked", K_INTR, 0, 0, 0);
		add_row("icr_mdac", K_RD, REG_ICR, 0, 64'(1) << INTR_MDAC);
		add_row("icr_clear", K_RD, REG_ICR, 0, 0);
		add_row("mdio_rd", K_MDIO_RD, 0, mdic_cmd(MDIO_OP_READ, 5'd2, 16'h0),
			64'(rdy | mdic_cmd(MDIO_OP_READ, 5'd2, phy_regs[2])));
		// MDAC from the read, now enabled
		add_row("ims_set", K_WR, REG_IMS, (32'h1 << INTR_MDAC) | (32'h1 << INTR_PHYINT), 0);
		add_row("intr_mdac", K_INTR, 0, 0, 1);
		add_row("icr_rd_mdac", K_RD, REG_ICR, 0, 64'(1) << INTR_MDAC);
		add_row("intr_clr", K_INTR, 0, 0, 0);
		add_row("imc_phyint", K_WR, REG_IMC, 32'h1 << INTR_PHYINT, 0);
		add_row("ims_rd", K_RD, REG_IMS, 0, 64'(1) << INTR_MDAC);
		add_row("imc_mdac", K_WR, REG_IMC, 32'h1 << INTR_MDAC, 0);
		add_row("ims_rd_zero", K_RD, REG_IMS, 0, 0);
		// Software cause through ICS
		add_row("ims_sw", K_WR, REG_IMS, 32'h4, 0);
		add_row("ics_sw", K_WR, REG_ICS, 32'h4, 0);
		add_row("intr_sw", K_INTR, 0, 0, 1);
		add_row("icr_sw", K_RD, REG_ICR, 0, 64'h4);
		add_row("intr_sw_off", K_INTR, 0, 0, 0);
		add_row("icr_sw_zero", K_RD, REG_ICR, 0, 0);
		add_row("phy_int", K_PHYINT, 0, 0, 64'(1) << INTR_PHYINT);
	endtask

	initial
	begin
		row_t r;
		logic [63:0] act;
		logic [31:0] rd;
		logic chk;
		void'($urandom(32'h0373439f));
		rst_i = 1'b1;
		awaddr_i = '0;
		awvalid_i = 1'b0;
		wdata_i = '0;
		wstrb_i = 4'hF;
		wvalid_i = 1'b0;
		bready_i = 1'b0;
		araddr_i = '0;
		arvalid_i = 1'b0;
		rready_i = 1'b0;
		mdio_i = 1'b1;
		phy_int_i = 1'b0;
		build_table();
		cycle_limit = rows.size() * 600;
		repeat (5) @(posedge aclk);
		// Output levels while reset is held
		if (phy_reset_o !== 1'b1 || mdio_o !== 1'b1 || mdio_oe_o !== 1'b0 || mdc_o !== 1'b0
			|| intr_o !== 1'b0 || bvalid_o !== 1'b0 || rvalid_o !== 1'b0)
		begin
			errors++;
			$display("Outputs are not at their reset levels while reset is held");
		end
		rst_i <= 1'b0;
		foreach (rows[i])
		begin
			r = rows[i];
			row_name = r.name;
			chk = 1'b1;
			act = '0;
			case (r.kind)
				K_WR:
				begin
					axi_write(r.addr, r.wdata);
					chk = 1'b0;
				end
				K_RD:
				begin
					axi_read(r.addr, rd);
					act = 64'(rd);
				end
				K_MDIO_WR:
				begin
					axi_write(REG_MDIC, r.wdata);
					wait_mdic_ready(rd);
					act = last_frame;
				end
				K_MDIO_RD:
				begin
					axi_write(REG_MDIC, r.wdata);
					wait_mdic_ready(rd);
					act = 64'(rd);
				end
				K_PHYINT:
				begin
					// Pulse wide enough to cross the synchronizer
					@(posedge aclk);
					phy_int_i <= 1'b1;
					repeat (6) @(posedge aclk);
					phy_int_i <= 1'b0;
					axi_read(REG_ICR, rd);
					act = 64'(rd);
				end
				K_INTR:
				begin
					// intr_o settles two cycles after the cause
					repeat (3) @(posedge aclk);
					act = 64'(intr_o);
				end
				default:
				begin
					@(posedge aclk);
					act = 64'(phy_reset_o);
				end
			endcase
			if (!chk)
				$display("done %s", r.name);
			else if (act !== r.exp)
			begin
				errors++;
				$display("ERR %s expected %h actual %h", r.name, r.exp, act);
			end
			else
				$display("ok   %s", r.name);
		end
		$display("%0d tests, %0d errors", rows.size(), errors);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

//--- project.f
hdl/nic_reg_pkg.sv
hdl/nic_intr_pkg.sv
hdl/mdio_req_if.sv
hdl/intr_reg_if.sv
hdl/nic_regs.sv
hdl/intr_ctrl.sv
hdl/mdio_master.sv
hdl/nic_ctrl_top.sv
testbench/nic_ctrl_properties.sv
testbench/tb_nic_ctrl.sv

//--- Makefile
SRCS := $(wildcard hdl/*.sv testbench/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vtb_nic_ctrl: project.f $(SRCS)
	verilator --binary --assert -Wno-fatal -j 0 -f project.f --top-module tb_nic_ctrl -Mdir obj_dir

run: obj_dir/Vtb_nic_ctrl
	./obj_dir/Vtb_nic_ctrl | tee sim.log
	@grep -qx "Simulation passed" sim.log || (echo "run did not pass, see sim.log" && exit 1)

clean:
	rm -rf obj_dir sim.log
